/* rv_fetch_settings.svh */
`ifndef RV_FETCH_SETTINGS_SVH
`define RV_FETCH_SETTINGS_SVH

// First fetch address after reset
`define RV_RESET_VECTOR 32'h0000_0000

// One-word lines, power of two
`define RV_ICACHE_LINES 16

// Entries between fetch and predecode
`define RV_QUEUE_DEPTH 2

`endif

/* rv_fetch_pkg.sv */
package rv_fetch_pkg;

	typedef logic [31:0] addr_t;
	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_idx_t;
	typedef logic [6:0] opcode_t;

	typedef enum logic [2:0] {
		ALU,
		LOAD,
		STORE,
		BRANCH,
		JUMP,
		SYSTEM,
		OTHER
	} inst_class_t;

	typedef enum logic [1:0] {
		FETCH,
		WAIT_JUMP,
		WAIT_IRQ
	} fetch_state_t;

	typedef enum logic {
		LOOKUP,
		REFILL
	} cache_state_t;

	// RV32I major opcodes
	localparam opcode_t OPC_LUI = 7'b0110111;
	localparam opcode_t OPC_AUIPC = 7'b0010111;
	localparam opcode_t OPC_JAL = 7'b1101111;
	localparam opcode_t OPC_JALR = 7'b1100111;
	localparam opcode_t OPC_BRANCH = 7'b1100011;
	localparam opcode_t OPC_LOAD = 7'b0000011;
	localparam opcode_t OPC_STORE = 7'b0100011;
	localparam opcode_t OPC_OP_IMM = 7'b0010011;
	localparam opcode_t OPC_OP = 7'b0110011;
	localparam opcode_t OPC_SYSTEM = 7'b1110011;

	// Full encodings of the system words that stop fetch
	localparam word_t INSN_ECALL = 32'h0000_0073;
	localparam word_t INSN_WFI = 32'h1050_0073;
	localparam word_t INSN_MRET = 32'h3020_0073;

endpackage

/* rv_fetch_ifs.sv */
// Fetch to instruction cache request channel
interface imem_if
	import rv_fetch_pkg::*;
();
	logic req;
	addr_t addr;
	logic ready;
	word_t rdata;

	modport fetch (
		output req,
		output addr,
		input ready,
		input rdata
	);

	modport cache (
		input req,
		input addr,
		output ready,
		output rdata
	);
endinterface

// Valid/ready stream of fetched words with their pc
interface inst_stream_if
	import rv_fetch_pkg::*;
();
	logic valid;
	addr_t pc;
	word_t instr;
	logic ready;

	modport source (output valid, output pc, output instr, input ready);
	modport sink (input valid, input pc, input instr, output ready);
endinterface

/* rv_icache.sv */
`include "rv_fetch_settings.svh"

module rv_icache
	import rv_fetch_pkg::*;
(
	input logic i_clock,
	input logic i_reset,
	imem_if.cache bus,
	output logic o_wb_cyc,
	output logic o_wb_stb,
	output addr_t o_wb_adr,
	input logic i_wb_ack,
	input word_t i_wb_dat
);
	localparam int LINES = `RV_ICACHE_LINES;
	localparam int IDX_W = $clog2(LINES);
	localparam int TAG_W = 32 - 2 - IDX_W;

	cache_state_t state;
	logic [LINES-1:0] line_valid;
	logic [TAG_W-1:0] tag_mem [LINES];
	word_t data_mem [LINES];

	logic [IDX_W-1:0] idx;
	logic [TAG_W-1:0] tag;
	logic hit;
	logic ready;
	word_t rdata;
	logic fill;

	// Word address splits into index and tag
	assign idx = bus.addr[IDX_W+1:2];
	assign tag = bus.addr[31:IDX_W+2];
	assign hit = line_valid[idx] && (tag_mem[idx] == tag);
	assign fill = (state == REFILL) && i_wb_ack;

	assign bus.ready = ready;
	assign bus.rdata = rdata;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= LOOKUP;
			line_valid <= '0;
			ready <= 1'b0;
			o_wb_cyc <= 1'b0;
			o_wb_stb <= 1'b0;
		end else begin
			ready <= 1'b0;
			case (state)
				LOOKUP: begin
					// The request is still high in the cycle it is answered
					if (bus.req && !ready) begin
						if (hit) begin
							ready <= 1'b1;
						end else begin
							o_wb_cyc <= 1'b1;
							o_wb_stb <= 1'b1;
							state <= REFILL;
						end
					end
				end
				REFILL: begin
					if (i_wb_ack) begin
						o_wb_cyc <= 1'b0;
						o_wb_stb <= 1'b0;
						line_valid[idx] <= 1'b1;
						ready <= 1'b1;
						state <= LOOKUP;
					end
				end
				default: state <= LOOKUP;
			endcase
		end
	end

	// Line arrays and answer word
	always_ff @(posedge i_clock) begin
		if (fill) begin
			tag_mem[idx] <= tag;
			data_mem[idx] <= i_wb_dat;
			rdata <= i_wb_dat;
		end else begin
			rdata <= data_mem[idx];
		end
		if (state == LOOKUP) begin
			o_wb_adr <= {bus.addr[31:2], 2'b00};
		end
	end

endmodule

/* rv_fetch.sv */
`include "rv_fetch_settings.svh"

module rv_fetch
	import rv_fetch_pkg::*;
(
	input logic i_clock,
	input logic i_reset,
	input logic i_jump,
	input addr_t i_jump_pc,
	input logic i_irq_pending,
	input addr_t i_irq_pc,
	output logic o_irq_dispatched,
	output addr_t o_irq_epc,
	imem_if.fetch mem,
	inst_stream_if.source out
);
	fetch_state_t state;
	addr_t pc;
	logic req;
	logic irq_prev;
	logic irq_hold;
	logic irq_edge;
	logic irq_take;
	logic slot_free;
	logic word_in;
	logic out_valid;
	addr_t out_pc;
	word_t out_instr;
	opcode_t opcode;
	logic is_transfer;
	logic is_halt;

	assign opcode = mem.rdata[6:0];
	// Anything that changes the flow waits for the jump port
	assign is_transfer = (opcode == OPC_JAL) || (opcode == OPC_JALR) ||
		(opcode == OPC_BRANCH) || (mem.rdata == INSN_MRET);
	assign is_halt = (mem.rdata == INSN_ECALL) || (mem.rdata == INSN_WFI);

	assign word_in = (state == FETCH) && req && mem.ready;
	assign slot_free = !out_valid || out.ready;

	// Edge is remembered until the cache request has been answered
	assign irq_edge = i_irq_pending && !irq_prev;
	assign irq_take = (irq_edge || irq_hold) && !req && (state != WAIT_JUMP);

	assign mem.req = req;
	assign mem.addr = pc;
	assign out.valid = out_valid;
	assign out.pc = out_pc;
	assign out.instr = out_instr;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= FETCH;
			pc <= `RV_RESET_VECTOR;
			req <= 1'b0;
			irq_prev <= 1'b0;
			irq_hold <= 1'b0;
			out_valid <= 1'b0;
			o_irq_dispatched <= 1'b0;
		end else begin
			irq_prev <= i_irq_pending;
			irq_hold <= (irq_edge || irq_hold) && !irq_take && (state != WAIT_JUMP);
			o_irq_dispatched <= 1'b0;
			if (out.ready) begin
				out_valid <= 1'b0;
			end
			if (irq_take) begin
				o_irq_dispatched <= 1'b1;
				pc <= i_irq_pc;
				state <= FETCH;
			end else begin
				case (state)
					FETCH: begin
						if (req) begin
							if (mem.ready) begin
								req <= 1'b0;
								out_valid <= 1'b1;
								if (is_transfer) begin
									state <= WAIT_JUMP;
								end else if (is_halt) begin
									state <= WAIT_IRQ;
								end else begin
									pc <= pc + 32'd4;
								end
							end
						end else if (slot_free) begin
							req <= 1'b1;
						end
					end
					WAIT_JUMP: begin
						if (i_jump) begin
							pc <= i_jump_pc;
							state <= FETCH;
						end
					end
					WAIT_IRQ: begin
						// Left only through irq_take
					end
					default: state <= FETCH;
				endcase
			end
		end
	end

	// Output slot and return address
	always_ff @(posedge i_clock) begin
		if (word_in) begin
			out_pc <= pc;
			out_instr <= mem.rdata;
		end
		if (irq_take) begin
			o_irq_epc <= pc;
		end
	end

endmodule

/* rv_fetch_queue.sv */
`include "rv_fetch_settings.svh"

module rv_fetch_queue
	import rv_fetch_pkg::*;
(
	input logic i_clock,
	input logic i_reset,
	inst_stream_if.sink in,
	inst_stream_if.source out
);
	localparam int DEPTH = `RV_QUEUE_DEPTH;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam logic [PTR_W:0] FULL_COUNT = (PTR_W + 1)'(DEPTH);
	localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);

	addr_t pc_mem [DEPTH];
	word_t instr_mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0] count;
	logic push;
	logic pop;

	assign in.ready = (count != FULL_COUNT);
	assign out.valid = (count != '0);
	assign out.pc = pc_mem[rd_ptr];
	assign out.instr = instr_mem[rd_ptr];

	assign push = in.valid && in.ready;
	assign pop = out.valid && out.ready;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
			end
			// Simultaneous push and pop leaves the count alone
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (push) begin
			pc_mem[wr_ptr] <= in.pc;
			instr_mem[wr_ptr] <= in.instr;
		end
	end

endmodule

/* rv_predecode.sv */
module rv_predecode
	import rv_fetch_pkg::*;
(
	input logic i_clock,
	input logic i_reset,
	inst_stream_if.sink in,
	input logic i_busy,
	output logic o_valid,
	output addr_t o_pc,
	output word_t o_instr,
	output reg_idx_t o_rs1,
	output reg_idx_t o_rs2,
	output reg_idx_t o_rd,
	output inst_class_t o_class
);
	opcode_t opcode;
	logic has_rs1;
	logic has_rs2;
	logic has_rd;
	inst_class_t cls;

	assign opcode = in.instr[6:0];

	// Register empty or being taken this cycle
	assign in.ready = !o_valid || !i_busy;

	always_comb begin
		has_rs1 = 1'b0;
		has_rs2 = 1'b0;
		has_rd = 1'b0;
		cls = OTHER;
		case (opcode)
			OPC_OP: begin
				cls = ALU;
				has_rs1 = 1'b1;
				has_rs2 = 1'b1;
				has_rd = 1'b1;
			end
			OPC_OP_IMM: begin
				cls = ALU;
				has_rs1 = 1'b1;
				has_rd = 1'b1;
			end
			OPC_LUI, OPC_AUIPC: begin
				cls = ALU;
				has_rd = 1'b1;
			end
			OPC_LOAD: begin
				cls = LOAD;
				has_rs1 = 1'b1;
				has_rd = 1'b1;
			end
			OPC_STORE, OPC_BRANCH: begin
				cls = (opcode == OPC_STORE) ? STORE : BRANCH;
				has_rs1 = 1'b1;
				has_rs2 = 1'b1;
			end
			OPC_JAL: begin
				cls = JUMP;
				has_rd = 1'b1;
			end
			// JALR and the CSR group are I format
			OPC_JALR, OPC_SYSTEM: begin
				cls = (opcode == OPC_JALR) ? JUMP : SYSTEM;
				has_rs1 = 1'b1;
				has_rd = 1'b1;
			end
			default: cls = OTHER;
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_valid <= 1'b0;
		end else if (in.ready) begin
			o_valid <= in.valid;
		end
	end

	always_ff @(posedge i_clock) begin
		if (in.valid && in.ready) begin
			o_pc <= in.pc;
			o_instr <= in.instr;
			o_rs1 <= has_rs1 ? in.instr[19:15] : '0;
			o_rs2 <= has_rs2 ? in.instr[24:20] : '0;
			o_rd <= has_rd ? in.instr[11:7] : '0;
			o_class <= cls;
		end
	end

endmodule

/* rv_frontend_top.sv */
module rv_frontend_top
	import rv_fetch_pkg::*;
(
	input logic i_clock,
	input logic i_reset,

	// Wishbone classic refill master
	output logic o_wb_cyc,
	output logic o_wb_stb,
	output addr_t o_wb_adr,
	input logic i_wb_ack,
	input word_t i_wb_dat,

	input logic i_jump,
	input addr_t i_jump_pc,

	input logic i_irq_pending,
	input addr_t i_irq_pc,
	output logic o_irq_dispatched,
	output addr_t o_irq_epc,

	// Downstream stage
	input logic i_busy,
	output logic o_valid,
	output addr_t o_pc,
	output word_t o_instr,
	output reg_idx_t o_rs1,
	output reg_idx_t o_rs2,
	output reg_idx_t o_rd,
	output inst_class_t o_class
);
	imem_if imem ();
	inst_stream_if fetch_stream ();
	inst_stream_if decode_stream ();

	rv_icache icache (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.bus(imem.cache),
		.o_wb_cyc(o_wb_cyc),
		.o_wb_stb(o_wb_stb),
		.o_wb_adr(o_wb_adr),
		.i_wb_ack(i_wb_ack),
		.i_wb_dat(i_wb_dat)
	);

	rv_fetch fetch (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_jump(i_jump),
		.i_jump_pc(i_jump_pc),
		.i_irq_pending(i_irq_pending),
		.i_irq_pc(i_irq_pc),
		.o_irq_dispatched(o_irq_dispatched),
		.o_irq_epc(o_irq_epc),
		.mem(imem.fetch),
		.out(fetch_stream.source)
	);

	rv_fetch_queue queue (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.in(fetch_stream.sink),
		.out(decode_stream.source)
	);

	rv_predecode predecode (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.in(decode_stream.sink),
		.i_busy(i_busy),
		.o_valid(o_valid),
		.o_pc(o_pc),
		.o_instr(o_instr),
		.o_rs1(o_rs1),
		.o_rs2(o_rs2),
		.o_rd(o_rd),
		.o_class(o_class)
	);

endmodule

/* rv_frontend_props.sv */
module rv_frontend_props
	import rv_fetch_pkg::*;
(
	input logic i_clock,
	input logic i_reset,
	input logic o_wb_cyc,
	input logic o_wb_stb,
	input addr_t o_wb_adr,
	input logic i_wb_ack,
	input logic i_busy,
	input logic o_valid,
	input addr_t o_pc,
	input word_t o_instr,
	input logic o_irq_dispatched
);
	// Number of failed properties
	int fail_count = 0;

	// Strobe and cyc stay up together until the slave answers
	stb_held: assert property (@(posedge i_clock) disable iff (i_reset)
		o_wb_stb && !i_wb_ack |=> o_wb_stb && o_wb_cyc)
		else begin
			$error("stb or cyc dropped before ack");
			fail_count++;
		end

	// Bus cycle ends right after the ack
	bus_release: assert property (@(posedge i_clock) disable iff (i_reset)
		i_wb_ack |=> !o_wb_cyc && !o_wb_stb)
		else begin
			$error("bus cycle still open after ack");
			fail_count++;
		end

	// Address held until the slave answers
	adr_stable: assert property (@(posedge i_clock) disable iff (i_reset)
		o_wb_stb && !i_wb_ack |=> $stable(o_wb_adr))
		else begin
			$error("wb address moved");
			fail_count++;
		end

	out_held: assert property (@(posedge i_clock) disable iff (i_reset)
		o_valid && i_busy |=> o_valid && $stable(o_pc) && $stable(o_instr))
		else begin
			$error("output changed while busy");
			fail_count++;
		end

	irq_pulse: assert property (@(posedge i_clock) disable iff (i_reset)
		o_irq_dispatched |=> !o_irq_dispatched)
		else begin
			$error("irq dispatch longer than one cycle");
			fail_count++;
		end
endmodule

bind rv_frontend_top rv_frontend_props props (.*);

/* rv_frontend_tb.sv */
`include "rv_fetch_settings.svh"

module rv_frontend_tb
	import rv_fetch_pkg::*;
();
	localparam int NUM_ROWS = 7;
	localparam int CYCLE_LIMIT = NUM_ROWS * 40;
	localparam int ACT_RESET = 0;
	localparam int ACT_JUMP = 1;
	localparam int ACT_IRQ = 2;
	// Bus expectation per row
	localparam int BUS_ANY = 0;
	localparam int BUS_REUSE = 1;
	localparam int BUS_REFILL = 2;

	logic i_clock;
	logic i_reset;
	logic o_wb_cyc;
	logic o_wb_stb;
	addr_t o_wb_adr;
	logic i_wb_ack;
	word_t i_wb_dat;
	logic i_jump;
	addr_t i_jump_pc;
	logic i_irq_pending;
	addr_t i_irq_pc;
	logic o_irq_dispatched;
	addr_t o_irq_epc;
	logic i_busy;
	logic o_valid;
	addr_t o_pc;
	word_t o_instr;
	reg_idx_t o_rs1;
	reg_idx_t o_rs2;
	reg_idx_t o_rd;
	inst_class_t o_class;

	word_t imem [64];
	string row_name [NUM_ROWS];
	int row_act [NUM_ROWS];
	addr_t row_pc [NUM_ROWS];
	int row_len [NUM_ROWS];
	int row_bus [NUM_ROWS];
	bit row_busy [NUM_ROWS];
	addr_t row_epc [NUM_ROWS];

	integer seed = 46976;
	int cycles = 0;
	int wb_cycles = 0;
	int errors = 0;
	int tests_failed = 0;
	bit busy_mode = 0;
	bit in_bus_cycle = 0;
	int ack_delay = 0;

	rv_frontend_top UUT (.*);

	always #2 i_clock = ~i_clock;

	always @(posedge i_clock) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: no progress after %0d cycles", cycles);
			$display("Simulation FAILED");
			$finish;
		end
	end

	// Wishbone slave with a random ack delay of 0 to 3 cycles
	always @(negedge i_clock) begin
		if (i_wb_ack) begin
			i_wb_ack = 1'b0;
		end else if (o_wb_cyc && o_wb_stb) begin
			if (!in_bus_cycle) begin
				in_bus_cycle = 1'b1;
				ack_delay = $random(seed) & 3;
				wb_cycles++;
			end
			if (ack_delay == 0) begin
				i_wb_ack = 1'b1;
				i_wb_dat = imem[o_wb_adr[7:2]];
				in_bus_cycle = 1'b0;
			end else begin
				ack_delay--;
			end
		end else begin
			in_bus_cycle = 1'b0;
		end
	end

	// Random busy bursts from downstream
	always @(negedge i_clock) begin
		if (busy_mode) begin
			i_busy = (($random(seed) & 3) == 0);
		end else begin
			i_busy = 1'b0;
		end
	end

	// Format rules of RV32I
	function automatic void expect_fields(input word_t w, output reg_idx_t rs1,
			output reg_idx_t rs2, output reg_idx_t rd, output inst_class_t cls);
		logic [7:0] fmt;
		case (w[6:0])
			7'b0110011, 7'b0010011, 7'b0110111, 7'b0010111: cls = ALU;
			7'b0000011: cls = LOAD;
			7'b0100011: cls = STORE;
			7'b1100011: cls = BRANCH;
			7'b1101111, 7'b1100111: cls = JUMP;
			7'b1110011: cls = SYSTEM;
			default: cls = OTHER;
		endcase
		// Encoding format letter
		case (w[6:0])
			7'b0110011: fmt = "R";
			7'b0010011, 7'b0000011, 7'b1100111, 7'b1110011: fmt = "I";
			7'b0100011: fmt = "S";
			7'b1100011: fmt = "B";
			7'b0110111, 7'b0010111: fmt = "U";
			7'b1101111: fmt = "J";
			default: fmt = "?";
		endcase
		rs1 = (fmt inside {"I", "S", "B", "R"}) ? w[19:15] : 5'd0;
		rs2 = (fmt inside {"S", "B", "R"}) ? w[24:20] : 5'd0;
		rd = (fmt inside {"R", "I", "U", "J"}) ? w[11:7] : 5'd0;
	endfunction

	task automatic check_value(input string test, input string field, input word_t exp,
			input word_t act);
		assert (exp == act) else begin
			$display("error %s %s: expected %h, actual %h", test, field, exp, act);
			errors++;
		end
	endtask

	task automatic set_row(input int r, input string name, input int act, input addr_t pc,
			input int len, input int bus, input bit busy, input addr_t epc);
		row_name[r] = name;
		row_act[r] = act;
		row_pc[r] = pc;
		row_len[r] = len;
		row_bus[r] = bus;
		row_busy[r] = busy;
		row_epc[r] = epc;
	endtask

	task automatic load_program();
		for (int i = 0; i < 64; i++) begin
			// addi x0, x0, i as filler
			imem[i] = {i[11:0], 20'h00013};
		end
		imem[0] = 32'h00510093;
		imem[1] = 32'h00822183;
		imem[2] = 32'h00532223;
		imem[3] = 32'h009403B3;
		imem[4] = 32'h00208463;
		imem[8] = 32'h12345537;
		imem[9] = 32'h010000EF;
		imem[12] = 32'h00100593;
		imem[13] = 32'h00000073;
		imem[14] = 32'hFFF60613;
		imem[15] = 32'h00008067;
	endtask

	task automatic apply_reset();
		@(negedge i_clock);
		i_reset = 1'b1;
		repeat (4) @(negedge i_clock);
		i_reset = 1'b0;
	endtask

	task automatic apply_jump(input addr_t pc);
		@(negedge i_clock);
		i_jump = 1'b1;
		i_jump_pc = pc;
		@(negedge i_clock);
		i_jump = 1'b0;
	endtask

	task automatic raise_irq(input string test, input addr_t pc, input addr_t epc);
		@(negedge i_clock);
		i_irq_pending = 1'b1;
		i_irq_pc = pc;
		do @(posedge i_clock); while (!o_irq_dispatched);
		check_value(test, "epc", epc, o_irq_epc);
		@(negedge i_clock);
		i_irq_pending = 1'b0;
	endtask

	task automatic run_row(input int r);
		int bus_before;
		int errors_before;
		addr_t exp_pc;
		word_t w;
		reg_idx_t rs1;
		reg_idx_t rs2;
		reg_idx_t rd;
		inst_class_t cls;
		bus_before = wb_cycles;
		errors_before = errors;
		case (row_act[r])
			ACT_RESET: apply_reset();
			ACT_JUMP: apply_jump(row_pc[r]);
			default: raise_irq(row_name[r], row_pc[r], row_epc[r]);
		endcase
		busy_mode = row_busy[r];
		for (int k = 0; k < row_len[r]; k++) begin
			do @(posedge i_clock); while (!(o_valid && !i_busy));
			exp_pc = row_pc[r] + 4 * k;
			w = imem[exp_pc[7:2]];
			expect_fields(w, rs1, rs2, rd, cls);
			check_value(row_name[r], "pc", exp_pc, o_pc);
			check_value(row_name[r], "instr", w, o_instr);
			check_value(row_name[r], "rs1", rs1, o_rs1);
			check_value(row_name[r], "rs2", rs2, o_rs2);
			check_value(row_name[r], "rd", rd, o_rd);
			check_value(row_name[r], "class", cls, o_class);
		end
		busy_mode = 0;
		// Fetch must stay stopped until the next start action
		repeat (6) begin
			@(posedge i_clock);
			assert (!(o_valid && !i_busy)) else begin
				$display("%s: a word came out after fetch should have stopped", row_name[r]);
				errors++;
			end
		end
		if (row_bus[r] == BUS_REUSE) begin
			check_value(row_name[r], "wb_cycles", bus_before, wb_cycles);
		end else if (row_bus[r] == BUS_REFILL) begin
			assert (wb_cycles > bus_before) else begin
				$display("%s: no Wishbone refill cycles after reset", row_name[r]);
				errors++;
			end
		end
		if (errors == errors_before) begin
			$display("test %s: ok", row_name[r]);
		end else begin
			$display("test %s: %0d errors", row_name[r], errors - errors_before);
			tests_failed++;
		end
	endtask

	initial begin
		i_clock = 1'b0;
		i_reset = 1'b1;
		i_wb_ack = 1'b0;
		i_wb_dat = '0;
		i_jump = 1'b0;
		i_jump_pc = '0;
		i_irq_pending = 1'b0;
		i_irq_pc = '0;
		i_busy = 1'b0;
		load_program();
		set_row(0, "seq_reset", ACT_RESET, `RV_RESET_VECTOR, 5, BUS_REFILL, 0, '0);
		set_row(1, "jump_jal", ACT_JUMP, 32'h20, 2, BUS_ANY, 0, '0);
		set_row(2, "jump_ecall", ACT_JUMP, 32'h30, 2, BUS_ANY, 0, '0);
		set_row(3, "irq_return", ACT_IRQ, 32'h38, 2, BUS_ANY, 0, 32'h34);
		set_row(4, "loop_reuse", ACT_JUMP, 32'h00, 5, BUS_REUSE, 0, '0);
		set_row(5, "busy_bursts", ACT_JUMP, 32'h00, 5, BUS_REUSE, 1, '0);
		set_row(6, "reset_refill", ACT_RESET, `RV_RESET_VECTOR, 5, BUS_REFILL, 0, '0);
		for (int r = 0; r < NUM_ROWS; r++) begin
			run_row(r);
		end
		$display("%0d tests, %0d failed, %0d errors, %0d assertion failures, %0d bus cycles",
			NUM_ROWS, tests_failed, errors, UUT.props.fail_count, wb_cycles);
		if (errors == 0 && UUT.props.fail_count == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

/* tb.f */
+incdir+.
rv_fetch_pkg.sv
rv_fetch_ifs.sv
rv_icache.sv
rv_fetch.sv
rv_fetch_queue.sv
rv_predecode.sv
rv_frontend_top.sv
rv_frontend_props.sv
rv_frontend_tb.sv

/* Bender.yml */
package:
  name: rv_frontend

sources:
  - include_dirs:
      - .
    files:
      - rv_fetch_pkg.sv
      - rv_fetch_ifs.sv
      - rv_icache.sv
      - rv_fetch.sv
      - rv_fetch_queue.sv
      - rv_predecode.sv
      - rv_frontend_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - rv_frontend_props.sv
      - rv_frontend_tb.sv
